// File: Bender.yml
package:
  name: cr16_controller

sources:
  # RTL in compile order
  - source/cr16_ctrl_pkg.sv
  - source/exec_ctrl_if.sv
  - source/phase_sequencer.sv
  - source/exec_decoder.sv
  - source/alu_decoder.sv
  - source/cr16_controller.sv
  # simulation only
  - target: test
    files:
      - test/cr16_controller_properties.sv
      - test/tb_cr16_controller.sv

// File: cr16_controller.f
source/cr16_ctrl_pkg.sv
source/exec_ctrl_if.sv
source/phase_sequencer.sv
source/exec_decoder.sv
source/alu_decoder.sv
source/cr16_controller.sv
test/cr16_controller_properties.sv
test/tb_cr16_controller.sv

// File: source/alu_decoder.sv
// phase-independent ALU function and operand source select of the CR16 control unit
`timescale 1ns/1ps

module alu_decoder
  import cr16_ctrl_pkg::*;
(
  input  opcode_e         opcode,
  input  logic      [3:0] opcode_ext,
  output alu_func_e       alu_sel,
  output logic            alu_src
);

  // immediate shifts ignore ext bit 0
  logic [3:0] imm_sh_ext;

  assign imm_sh_ext = {opcode_ext[3:1], 1'b0};

  // alu_src 0 picks Rsrc, 1 picks the extended immediate
  always_comb begin
    // ADD from Rsrc for anything not using the ALU
    alu_src = 1'b0;
    alu_sel = ALU_ADD;

    case (opcode)
      OP_RS_RD: begin
        case (opcode_ext)
          RR_AND:  alu_sel = ALU_AND;
          RR_OR:   alu_sel = ALU_OR;
          RR_XOR:  alu_sel = ALU_XOR;
          RR_ADD:  alu_sel = ALU_ADD;
          RR_SUB:  alu_sel = ALU_SUB;
          RR_CMP:  alu_sel = ALU_SUB;  // compare is a subtract without write
          RR_MUL:  alu_sel = ALU_MUL;
          default: alu_sel = ALU_ADD;
        endcase
      end

      // ******************************
      // shifts
      // ******************************
      OP_SH: begin
        if (imm_sh_ext == SH_LSHI) begin
          alu_src = 1'b1;
          alu_sel = ALU_LSH;
        end else if (imm_sh_ext == SH_ASHUI) begin
          alu_src = 1'b1;
          alu_sel = ALU_ASH;
        end else if (opcode_ext == SH_LSH) begin
          alu_sel = ALU_LSH;
        end else if (opcode_ext == SH_ASHU) begin
          alu_sel = ALU_ASH;
        end
      end

      // immediate operands
      OP_ANDI: begin
        alu_src = 1'b1;
        alu_sel = ALU_AND;
      end
      OP_ORI: begin
        alu_src = 1'b1;
        alu_sel = ALU_OR;
      end
      OP_XORI: begin
        alu_src = 1'b1;
        alu_sel = ALU_XOR;
      end
      OP_ADDI: begin
        alu_src = 1'b1;
        alu_sel = ALU_ADD;
      end
      OP_SUBI, OP_CMPI: begin
        alu_src = 1'b1;
        alu_sel = ALU_SUB;
      end
      OP_MULI: begin
        alu_src = 1'b1;
        alu_sel = ALU_MUL;
      end
      // loads, stores, jumps, branches and moves
      default: begin
      end
    endcase
  end

endmodule

// File: source/cr16_controller.sv
// top level of the CR16 control unit, plain ports towards the datapath and memory
`timescale 1ns/1ps

module cr16_controller
  import cr16_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  // from the datapath
  input  logic [3:0] opcode,
  input  logic [3:0] opcode_ext,
  input  logic       cmp_result,
  // to the datapath
  output logic       reg_wr_en,
  output logic       alu_src,
  output logic [3:0] alu_sel,
  output logic       next_instr,
  output logic       pc_en,
  output logic       instr_en,
  output logic       cmp_f_en,
  output logic       of_f_en,
  output logic       z_f_en,
  output logic [1:0] pc_addr_mode,
  output logic [2:0] write_back_sel,
  output logic [1:0] sign_ext_mode,
  // to memory
  output logic       mem_wr_en
);

  opcode_e opcode_dec;
  logic    execute;

  exec_ctrl_if ctrl_if ();

  // raw opcode bits as the enum, reserved codes pass through unchanged
  assign opcode_dec = opcode_e'(opcode);

  // ******************************
  // sequencer and decoders
  // ******************************

  phase_sequencer u_seq (
    .clk        (clk),
    .reset_n    (reset_n),
    .instr_en   (instr_en),
    .next_instr (next_instr),
    .pc_en      (pc_en),
    .execute    (execute)
  );

  exec_decoder u_exec_dec (
    .execute    (execute),
    .opcode     (opcode_dec),
    .opcode_ext (opcode_ext),
    .cmp_result (cmp_result),
    .ctrl       (ctrl_if.decoder)
  );

  alu_decoder u_alu_dec (
    .opcode     (opcode_dec),
    .opcode_ext (opcode_ext),
    .alu_sel    (alu_sel),
    .alu_src    (alu_src)
  );

  // execute bundle out to plain ports
  assign reg_wr_en      = ctrl_if.reg_wr_en;
  assign mem_wr_en      = ctrl_if.mem_wr_en;
  assign cmp_f_en       = ctrl_if.cmp_f_en;
  assign of_f_en        = ctrl_if.of_f_en;
  assign z_f_en         = ctrl_if.z_f_en;
  assign write_back_sel = ctrl_if.wb_sel;
  assign sign_ext_mode  = ctrl_if.ext_mode;
  assign pc_addr_mode   = ctrl_if.pc_mode;

endmodule

// File: source/cr16_ctrl_pkg.sv
// shared encodings for the CR16 control unit; imported by every RTL block of the controller
package cr16_ctrl_pkg;

  // ******************************
  // instruction fields
  // ******************************

  // primary opcode, upper nibble of the instruction
  // codes 6, 7 and 10 are reserved and decode to no effect
  typedef enum logic [3:0] {
    OP_RS_RD   = 4'b0000,  // register-register group, selected by extension
    OP_ANDI    = 4'b0001,
    OP_ORI     = 4'b0010,
    OP_XORI    = 4'b0011,
    OP_LD_ST_J = 4'b0100,  // load, store and jump group
    OP_ADDI    = 4'b0101,
    OP_SH      = 4'b1000,  // shift group
    OP_SUBI    = 4'b1001,
    OP_CMPI    = 4'b1011,
    OP_BCOND   = 4'b1100,
    OP_MOVI    = 4'b1101,
    OP_MULI    = 4'b1110,
    OP_LUI     = 4'b1111
  } opcode_e;

  // register-register extensions
  // ADDU, ADDC and SUBC are named by the ISA but have no effect here
  typedef enum logic [3:0] {
    RR_AND  = 4'b0001,
    RR_OR   = 4'b0010,
    RR_XOR  = 4'b0011,
    RR_ADD  = 4'b0101,
    RR_ADDU = 4'b0110,
    RR_ADDC = 4'b0111,
    RR_SUB  = 4'b1001,
    RR_SUBC = 4'b1010,
    RR_CMP  = 4'b1011,
    RR_MOV  = 4'b1101,
    RR_MUL  = 4'b1110
  } rr_ext_e;

  // shift extensions, bit 0 is don't care on the immediate forms
  typedef enum logic [3:0] {
    SH_LSHI  = 4'b0000,
    SH_ASHUI = 4'b0010,
    SH_LSH   = 4'b0100,
    SH_ASHU  = 4'b0110
  } sh_ext_e;

  // load, store and jump extensions
  typedef enum logic [3:0] {
    LSJ_LOAD  = 4'b0000,
    LSJ_STOR  = 4'b0100,
    LSJ_JAL   = 4'b1000,
    LSJ_JCOND = 4'b1100
  } lsj_ext_e;

  // ******************************
  // datapath controls
  // ******************************

  // ALU function select
  typedef enum logic [3:0] {
    ALU_ADD = 4'b0000,
    ALU_SUB = 4'b0001,
    ALU_AND = 4'b0010,
    ALU_OR  = 4'b0011,
    ALU_XOR = 4'b0100,
    ALU_NOT = 4'b0101,
    ALU_LSH = 4'b0110,
    ALU_ASH = 4'b0111,
    ALU_MUL = 4'b1000
  } alu_func_e;

  // source of register file write data
  typedef enum logic [2:0] {
    WB_ALU = 3'h0,
    WB_MEM = 3'h1,
    WB_REG = 3'h2,
    WB_IMM = 3'h3,
    WB_PC  = 3'h4
  } wb_src_e;

  // next PC computation
  typedef enum logic [1:0] {
    PC_INCREMENT = 2'b00,
    PC_OFFSET    = 2'b01,  // relative branch
    PC_ABSOLUTE  = 2'b10   // jump target from register
  } pc_mode_e;

  // immediate extension
  typedef enum logic [1:0] {
    SIGN_EXTEND = 2'b00,  // two's complement
    ZERO_EXTEND = 2'b01,  // pad upper bits with zeros
    ALIGN_HIGH  = 2'b10   // immediate goes in the upper byte
  } ext_mode_e;

  // sequencer phase
  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    FETCH   = 2'b01,
    EXECUTE = 2'b10
  } phase_e;

endpackage

// File: source/exec_ctrl_if.sv
// execute-phase control bundle between the execute decoder and the controller top level
`timescale 1ns/1ps

interface exec_ctrl_if
  import cr16_ctrl_pkg::*;
();

  // write enables
  logic      reg_wr_en;
  logic      mem_wr_en;

  // flag register enables
  logic      cmp_f_en;
  logic      of_f_en;
  logic      z_f_en;

  // datapath selects
  wb_src_e   wb_sel;
  ext_mode_e ext_mode;
  pc_mode_e  pc_mode;

  // decoder side drives the whole bundle
  modport decoder (
    output reg_wr_en, mem_wr_en, cmp_f_en, of_f_en, z_f_en,
    output wb_sel, ext_mode, pc_mode
  );

  // consumer side only reads
  modport sink (
    input reg_wr_en, mem_wr_en, cmp_f_en, of_f_en, z_f_en,
    input wb_sel, ext_mode, pc_mode
  );

endinterface

// File: source/exec_decoder.sv
// execute-phase decoder: write enables, flag enables and datapath selects of one instruction
`timescale 1ns/1ps

module exec_decoder
  import cr16_ctrl_pkg::*;
(
  input  logic         execute,
  input  opcode_e      opcode,
  input  logic   [3:0] opcode_ext,
  input  logic         cmp_result,
  exec_ctrl_if.decoder ctrl
);

  // shift extension with the don't care bit cleared
  logic [3:0] imm_sh_ext;

  assign imm_sh_ext = {opcode_ext[3:1], 1'b0};

  always_comb begin
    // inactive defaults, also what fetch and idle see
    ctrl.reg_wr_en = 1'b0;
    ctrl.mem_wr_en = 1'b0;
    ctrl.cmp_f_en  = 1'b0;
    ctrl.of_f_en   = 1'b0;
    ctrl.z_f_en    = 1'b0;
    ctrl.wb_sel    = WB_ALU;
    ctrl.ext_mode  = SIGN_EXTEND;
    ctrl.pc_mode   = PC_INCREMENT;

    if (execute) begin
      case (opcode)
        // ******************************
        // register-register group
        // ******************************
        OP_RS_RD: begin
          case (opcode_ext)
            RR_AND, RR_OR, RR_MUL: begin
              ctrl.reg_wr_en = 1'b1;
              ctrl.z_f_en    = 1'b1;
            end
            RR_ADD: begin
              ctrl.reg_wr_en = 1'b1;
              ctrl.z_f_en    = 1'b1;
              ctrl.of_f_en   = 1'b1;
            end
            // subtract updates every flag
            RR_SUB: begin
              ctrl.reg_wr_en = 1'b1;
              ctrl.z_f_en    = 1'b1;
              ctrl.of_f_en   = 1'b1;
              ctrl.cmp_f_en  = 1'b1;
            end
            // compare only touches flags
            RR_CMP: begin
              ctrl.z_f_en   = 1'b1;
              ctrl.cmp_f_en = 1'b1;
            end
            // copy Rsrc straight into Rdest
            RR_MOV: begin
              ctrl.reg_wr_en = 1'b1;
              ctrl.wb_sel    = WB_REG;
            end
            // register XOR and unused extensions do nothing
            default: begin
            end
          endcase
        end

        // ******************************
        // load, store and jump group
        // ******************************
        OP_LD_ST_J: begin
          case (opcode_ext)
            LSJ_LOAD: begin
              ctrl.reg_wr_en = 1'b1;
              ctrl.wb_sel    = WB_MEM;
            end
            LSJ_STOR: begin
              ctrl.mem_wr_en = 1'b1;
            end
            // link register gets the PC, then jump
            LSJ_JAL: begin
              ctrl.reg_wr_en = 1'b1;
              ctrl.wb_sel    = WB_PC;
              ctrl.pc_mode   = PC_ABSOLUTE;
            end
            // jump only when the condition held
            LSJ_JCOND: begin
              ctrl.pc_mode = cmp_result ? PC_ABSOLUTE : PC_INCREMENT;
            end
            default: begin
            end
          endcase
        end

        // the four shifts write back the ALU result
        OP_SH: begin
          if (imm_sh_ext == SH_LSHI || imm_sh_ext == SH_ASHUI ||
              opcode_ext == SH_LSH || opcode_ext == SH_ASHU) begin
            ctrl.reg_wr_en = 1'b1;
          end
        end

        // ******************************
        // immediate group
        // ******************************
        // logic immediates are zero extended
        OP_ANDI, OP_ORI, OP_XORI: begin
          ctrl.reg_wr_en = 1'b1;
          ctrl.z_f_en    = 1'b1;
          ctrl.ext_mode  = ZERO_EXTEND;
        end
        OP_ADDI, OP_SUBI: begin
          ctrl.reg_wr_en = 1'b1;
          ctrl.z_f_en    = 1'b1;
          ctrl.of_f_en   = 1'b1;
        end
        OP_CMPI: begin
          ctrl.z_f_en   = 1'b1;
          ctrl.cmp_f_en = 1'b1;
        end
        OP_MULI: begin
          ctrl.reg_wr_en = 1'b1;
          ctrl.z_f_en    = 1'b1;
        end
        // relative branch when the condition held
        OP_BCOND: begin
          ctrl.pc_mode = cmp_result ? PC_OFFSET : PC_INCREMENT;
        end
        OP_MOVI: begin
          ctrl.reg_wr_en = 1'b1;
          ctrl.wb_sel    = WB_IMM;
          ctrl.ext_mode  = ZERO_EXTEND;
        end
        // immediate lands in the upper byte
        OP_LUI: begin
          ctrl.reg_wr_en = 1'b1;
          ctrl.wb_sel    = WB_IMM;
          ctrl.ext_mode  = ALIGN_HIGH;
        end
        // reserved opcodes only advance the PC
        default: begin
        end
      endcase
    end
  end

endmodule

// File: source/phase_sequencer.sv
// two-phase fetch/execute sequencer of the CR16 control unit, drives the fetch and PC strobes
`timescale 1ns/1ps

module phase_sequencer
  import cr16_ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset_n,
  output logic instr_en,
  output logic next_instr,
  output logic pc_en,
  output logic execute
);

  phase_e phase;
  phase_e phase_next;

  // ******************************
  // phase register
  // ******************************

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      phase <= IDLE;
    end else begin
      phase <= phase_next;
    end
  end

  // idle and execute both lead to fetch
  always_comb begin
    case (phase)
      FETCH:   phase_next = EXECUTE;
      default: phase_next = FETCH;
    endcase
  end

  // ******************************
  // phase strobes
  // ******************************

  // fetch loads the instruction register, PC drives the memory address
  assign instr_en   = (phase == FETCH);
  assign next_instr = (phase == FETCH);

  // execute commits the next PC
  assign pc_en   = (phase == EXECUTE);
  assign execute = (phase == EXECUTE);

endmodule

// File: test/controller_input.txt
// op ext cmp_result  reg_wr mem_wr cmp_f of_f z_f  wb_sel ext_mode pc_mode  alu_sel alu_src
// one instruction per line, every field in hex, expected values are the execute-phase outputs
0 1 0  1 0 0 0 1  0 0 0  2 0  // AND
0 2 0  1 0 0 0 1  0 0 0  3 0  // OR
0 3 1  0 0 0 0 0  0 0 0  4 0  // XOR register form, no effect
0 5 0  1 0 0 1 1  0 0 0  0 0  // ADD
0 9 0  1 0 1 1 1  0 0 0  1 0  // SUB
0 b 0  0 0 1 0 1  0 0 0  1 0  // CMP
0 d 0  1 0 0 0 0  2 0 0  0 0  // MOV
0 e 0  1 0 0 0 1  0 0 0  8 0  // MUL
8 0 0  1 0 0 0 0  0 0 0  6 1  // LSHI
8 1 1  1 0 0 0 0  0 0 0  6 1  // LSHI with bit 0 set
8 3 0  1 0 0 0 0  0 0 0  7 1  // ASHUI with bit 0 set
8 4 0  1 0 0 0 0  0 0 0  6 0  // LSH
8 6 1  1 0 0 0 0  0 0 0  7 0  // ASHU
1 7 0  1 0 0 0 1  0 1 0  2 1  // ANDI
2 0 0  1 0 0 0 1  0 1 0  3 1  // ORI
3 f 1  1 0 0 0 1  0 1 0  4 1  // XORI
5 2 0  1 0 0 1 1  0 0 0  0 1  // ADDI
9 4 0  1 0 0 1 1  0 0 0  1 1  // SUBI
b 9 1  0 0 1 0 1  0 0 0  1 1  // CMPI
d 6 0  1 0 0 0 0  3 1 0  0 0  // MOVI
e 3 0  1 0 0 0 1  0 0 0  8 1  // MULI
f a 1  1 0 0 0 0  3 2 0  0 0  // LUI
4 0 0  1 0 0 0 0  1 0 0  0 0  // LOAD
4 4 1  0 1 0 0 0  0 0 0  0 0  // STOR
4 8 0  1 0 0 0 0  4 0 2  0 0  // JAL
4 c 0  0 0 0 0 0  0 0 0  0 0  // Jcond not taken
4 c 1  0 0 0 0 0  0 0 2  0 0  // Jcond taken
c 5 0  0 0 0 0 0  0 0 0  0 0  // Bcond not taken
c 5 1  0 0 0 0 0  0 0 1  0 0  // Bcond taken

// File: test/cr16_controller_properties.sv
// strobe and write-enable rules of the CR16 controller, bound to the top level in simulation
`timescale 1ns/1ps

module cr16_controller_properties (
  input logic clk,
  input logic reset_n,
  input logic instr_en,
  input logic pc_en,
  input logic reg_wr_en,
  input logic mem_wr_en
);

  // fetch and execute are exclusive phases
  phase_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(instr_en && pc_en))
    else $error("instr_en and pc_en high in the same cycle");

  // execute always hands back to fetch
  exec_then_fetch: assert property (@(posedge clk) disable iff (!reset_n)
    pc_en |=> instr_en)
    else $error("pc_en cycle not followed by an instr_en cycle");

  // one write target per instruction
  single_write: assert property (@(posedge clk) disable iff (!reset_n)
    !(mem_wr_en && reg_wr_en))
    else $error("mem_wr_en and reg_wr_en high together");

  // stores only commit in execute
  store_in_exec: assert property (@(posedge clk) disable iff (!reset_n)
    mem_wr_en |-> pc_en)
    else $error("mem_wr_en high outside the execute phase");

endmodule

bind cr16_controller cr16_controller_properties props0 (
  .clk       (clk),
  .reset_n   (reset_n),
  .instr_en  (instr_en),
  .pc_en     (pc_en),
  .reg_wr_en (reg_wr_en),
  .mem_wr_en (mem_wr_en)
);

// File: test/tb_cr16_controller.sv
// testbench of the CR16 controller, runs file vectors and random reserved opcodes through dut0
`timescale 1ns/1ps

module tb_cr16_controller;

  localparam int          FIELDS      = 13;
  localparam int          MAX_VECTORS = 64;
  localparam int          N_RANDOM    = 12;
  localparam logic [31:0] SEED        = 32'h6945b2f1;

  // DUT inputs
  logic       clk;
  logic       reset_n;
  logic [3:0] opcode;
  logic [3:0] opcode_ext;
  logic       cmp_result;

  // DUT outputs
  logic       reg_wr_en;
  logic       alu_src;
  logic [3:0] alu_sel;
  logic       next_instr;
  logic       pc_en;
  logic       instr_en;
  logic       cmp_f_en;
  logic       of_f_en;
  logic       z_f_en;
  logic [1:0] pc_addr_mode;
  logic [2:0] write_back_sel;
  logic [1:0] sign_ext_mode;
  logic       mem_wr_en;

  // vector fields, FIELDS entries per instruction
  logic [3:0] vec_mem [0:FIELDS*MAX_VECTORS-1];

  // expected execute-phase values of the current instruction
  logic       e_reg;
  logic       e_mem;
  logic       e_cmpf;
  logic       e_of;
  logic       e_z;
  logic [2:0] e_wb;
  logic [1:0] e_ext;
  logic [1:0] e_pc;
  logic [3:0] e_alu;
  logic       e_src;

  int file_count   = 0;
  int vec_total    = 0;
  int checks       = 0;
  int value_errors = 0;
  int other_errors = 0;

  cr16_controller dut0 (
    .clk            (clk),
    .reset_n        (reset_n),
    .opcode         (opcode),
    .opcode_ext     (opcode_ext),
    .cmp_result     (cmp_result),
    .reg_wr_en      (reg_wr_en),
    .alu_src        (alu_src),
    .alu_sel        (alu_sel),
    .next_instr     (next_instr),
    .pc_en          (pc_en),
    .instr_en       (instr_en),
    .cmp_f_en       (cmp_f_en),
    .of_f_en        (of_f_en),
    .z_f_en         (z_f_en),
    .pc_addr_mode   (pc_addr_mode),
    .write_back_sel (write_back_sel),
    .sign_ext_mode  (sign_ext_mode),
    .mem_wr_en      (mem_wr_en)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ******************************
  // helpers
  // ******************************

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    lcg_next = state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_field(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
      value_errors++;
    end
  endtask

  // the eight decoded execute controls
  task automatic check_decoded(input logic rw, input logic mw, input logic cf,
                               input logic of, input logic zf, input logic [2:0] wb,
                               input logic [1:0] ext, input logic [1:0] pcm);
    check_field("reg_wr_en", rw, reg_wr_en);
    check_field("mem_wr_en", mw, mem_wr_en);
    check_field("cmp_f_en", cf, cmp_f_en);
    check_field("of_f_en", of, of_f_en);
    check_field("z_f_en", zf, z_f_en);
    check_field("write_back_sel", wb, write_back_sel);
    check_field("sign_ext_mode", ext, sign_ext_mode);
    check_field("pc_addr_mode", pcm, pc_addr_mode);
  endtask

  // outside execute every decoded control sits at its inactive default
  task automatic check_phase(input logic fetch_exp, input logic exec_exp);
    check_field("instr_en", fetch_exp, instr_en);
    check_field("next_instr", fetch_exp, next_instr);
    check_field("pc_en", exec_exp, pc_en);
    if (exec_exp) begin
      check_decoded(e_reg, e_mem, e_cmpf, e_of, e_z, e_wb, e_ext, e_pc);
    end else begin
      check_decoded(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3'h0, 2'h0, 2'h0);
    end
    // ALU select follows the opcode in any phase
    check_field("alu_sel", e_alu, alu_sel);
    check_field("alu_src", e_src, alu_src);
  endtask

  // one instruction: drive in fetch, hold through execute
  task automatic run_vector(input logic [3:0] op, input logic [3:0] ext, input logic cmp);
    @(posedge clk);
    #1;
    opcode     = op;
    opcode_ext = ext;
    cmp_result = cmp;
    #18;
    check_phase(1'b1, 1'b0);
    @(posedge clk);
    #19;
    check_phase(1'b0, 1'b1);
  endtask

  // reserved instructions only advance the PC
  task automatic expect_no_effect();
    {e_reg, e_mem, e_cmpf, e_of, e_z} = 5'b0;
    e_wb  = 3'h0;
    e_ext = 2'h0;
    e_pc  = 2'h0;
    e_alu = 4'h0;
    e_src = 1'b0;
  endtask

  // ******************************
  // main sequence
  // ******************************

  initial begin : main
    int          i;
    int          base;
    logic [31:0] rnd;
    logic [3:0]  rsv_op;

    reset_n    = 1'b0;
    opcode     = 4'h0;
    opcode_ext = 4'h0;
    cmp_result = 1'b0;

    $readmemh("test/controller_input.txt", vec_mem);
    while (file_count < MAX_VECTORS && !$isunknown(vec_mem[file_count*FIELDS])) begin
      file_count++;
    end
    assert (file_count > 0) else begin
      $display("no vectors could be read from test/controller_input.txt");
      other_errors++;
    end
    vec_total = file_count + N_RANDOM;

    // opcode 0 with ext 0 selects ADD from Rsrc
    expect_no_effect();

    // reset low over two edges, then one idle cycle
    @(posedge clk);
    #19;
    check_phase(1'b0, 1'b0);
    @(posedge clk);
    #1;
    reset_n = 1'b1;
    #18;
    check_phase(1'b0, 1'b0);

    // first fetch must come right after the idle cycle
    for (i = 0; i < file_count; i++) begin
      base   = i * FIELDS;
      e_reg  = vec_mem[base+3][0];
      e_mem  = vec_mem[base+4][0];
      e_cmpf = vec_mem[base+5][0];
      e_of   = vec_mem[base+6][0];
      e_z    = vec_mem[base+7][0];
      e_wb   = vec_mem[base+8][2:0];
      e_ext  = vec_mem[base+9][1:0];
      e_pc   = vec_mem[base+10][1:0];
      e_alu  = vec_mem[base+11];
      e_src  = vec_mem[base+12][0];
      run_vector(vec_mem[base], vec_mem[base+1], vec_mem[base+2][0]);
    end

    // random extensions under the reserved opcodes
    rnd = SEED;
    for (i = 0; i < N_RANDOM; i++) begin
      rnd = lcg_next(rnd);
      case ((rnd >> 16) % 3)
        0:       rsv_op = 4'd6;
        1:       rsv_op = 4'd7;
        default: rsv_op = 4'd10;
      endcase
      expect_no_effect();
      run_vector(rsv_op, rnd[11:8], rnd[4]);
    end

    $display("summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // two cycles per instruction plus margin for reset
  initial begin : watchdog
    wait (vec_total != 0);
    repeat (vec_total * 2 + 10) @(posedge clk);
    $display("timeout: run did not complete within %0d cycles", vec_total * 2 + 10);
    $display("summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors + 1);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
